// ==== src/itlb_pkg.sv ====
/*
 * Shared widths, entry field positions and encodings for the instruction TLB.
 * RTL and bench files reach these through itlb_pkg:: scoped names.
 */
package itlb_pkg;

    // ****************************************
    // Table geometry
    // ****************************************
    localparam int NUM_ENTRIES = 32;
    localparam int IDX_W       = 5;
    localparam int VPN_W       = 27;  // Sv39 virtual page number
    localparam int PPN_W       = 44;
    localparam int ENTRY_W     = 91;

    // ****************************************
    // Entry layout, PPN on top, VPN below it
    // ****************************************
    localparam int ENTRY_V_BIT = 0;
    localparam int ENTRY_U_BIT = 4;                  // User page
    localparam int PPN_LSB     = ENTRY_W - PPN_W;    // 47
    localparam int VPN_LSB     = PPN_LSB - VPN_W;    // 20, above the permission bits

    // Mode field of satp
    localparam logic [3:0] SATP_MODE_BARE = 4'd0;

    // ****************************************
    // Types
    // ****************************************
    typedef logic [IDX_W-1:0]       idx_t;
    typedef logic [VPN_W-1:0]       vpn_t;
    typedef logic [PPN_W-1:0]       ppn_t;
    typedef logic [ENTRY_W-1:0]     entry_t;      // Raw page table entry
    typedef logic [NUM_ENTRIES-1:0] match_t;      // One bit per slot
    typedef logic [3:0]             satp_mode_t;

    // Privilege level of the fetch
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

endpackage

// ==== src/itlb_entry_store.sv ====
/*
 * Entry table of the instruction TLB with one valid bit per slot.
 * Refill writes a slot by index; flush drops every valid bit at once.
 */
`timescale 1ns/1ps

module itlb_entry_store (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  itlb_pkg::idx_t       write_index,
    input  itlb_pkg::entry_t     write_entry,
    input  logic                 flush,
    output itlb_pkg::entry_t     entries [itlb_pkg::NUM_ENTRIES],
    output itlb_pkg::match_t     valid
);

    // ****************************************
    // Valid bits
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;  // Flush beats a refill in the same cycle
        end else if (we) begin
            valid[write_index] <= 1'b1;
        end
    end

    // ****************************************
    // Entry table
    // ****************************************
    // Data is still written under flush, the slot just stays invalid
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < itlb_pkg::NUM_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[write_index] <= write_entry;
        end
    end

    // Written slot must come out invalid when flush hits the same edge
    flush_over_write_a: assert property (
        @(posedge clk) disable iff (rst)
        (flush && we) |=> !valid[$past(write_index)]
    ) else $error("slot %0d valid after flush with write", $past(write_index));

endmodule

// ==== src/itlb_tag_match.sv ====
/*
 * Decode stage of the instruction TLB lookup.
 * Compares the incoming VPN against every slot at once and gives a one-hot
 * match vector together with the raw hit.
 */
`timescale 1ns/1ps

module itlb_tag_match (
    input  logic                 re,
    input  itlb_pkg::vpn_t       vpn,
    input  itlb_pkg::entry_t     entries [itlb_pkg::NUM_ENTRIES],
    input  itlb_pkg::match_t     valid,
    output itlb_pkg::match_t     match,
    output logic                 hit_raw
);

    // ****************************************
    // Parallel tag compare
    // ****************************************
    always_comb begin
        for (int t = 0; t < itlb_pkg::NUM_ENTRIES; t++) begin
            // Slot valid bit and the PTE's own V bit both needed
            match[t] = re
                     & valid[t]
                     & entries[t][itlb_pkg::ENTRY_V_BIT]
                     & (entries[t][itlb_pkg::VPN_LSB +: itlb_pkg::VPN_W] == vpn);
        end
    end

    assign hit_raw = |match;  // Any slot

    // Refill never leaves two valid slots on the same VPN
    match_onehot_a: assert final ($isunknown(match) || $onehot0(match))
        else $error("more than one TLB slot matches vpn %h", vpn);

endmodule

// ==== src/itlb_perm_check.sv ====
/*
 * Execute stage of the instruction TLB lookup.
 * Turns the one-hot match into an index, picks that slot's PPN and
 * checks the U bit against the current privilege level.
 */
`timescale 1ns/1ps

module itlb_perm_check (
    input  itlb_pkg::match_t     match,
    input  itlb_pkg::entry_t     entries [itlb_pkg::NUM_ENTRIES],
    input  itlb_pkg::priv_e      priv,
    output itlb_pkg::ppn_t       sel_ppn,
    output itlb_pkg::idx_t       sel_index,
    output logic                 sel_fault
);

    logic user_page;  // U bit of the selected slot
    logic any_match;

    // ****************************************
    // Entry select
    // ****************************************
    // At most one bit is set, so the last hit in the loop is the only one
    always_comb begin
        sel_ppn   = '0;
        sel_index = '0;
        user_page = 1'b0;
        for (int i = 0; i < itlb_pkg::NUM_ENTRIES; i++) begin
            if (match[i]) begin
                sel_ppn   = entries[i][itlb_pkg::PPN_LSB +: itlb_pkg::PPN_W];
                sel_index = itlb_pkg::idx_t'(i);
                user_page = entries[i][itlb_pkg::ENTRY_U_BIT];
            end
        end
    end

    assign any_match = |match;

    // ****************************************
    // Privilege check
    // ****************************************
    always_comb begin
        sel_fault = 1'b0;
        if (any_match) begin
            case (priv)
                itlb_pkg::PRIV_S: sel_fault = user_page;   // No fetch from U pages
                itlb_pkg::PRIV_U: sel_fault = !user_page;  // U only runs U pages
                default:          sel_fault = 1'b0;        // M sees everything
            endcase
        end
    end

endmodule

// ==== src/itlb_result_reg.sv ====
/*
 * Result stage of the instruction TLB lookup.
 * Registers either the translated result or the Bare/M-mode bypass on re,
 * and zeros when no lookup is issued. One cycle of latency.
 */
`timescale 1ns/1ps

module itlb_result_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   re,
    input  itlb_pkg::vpn_t         vpn,
    input  itlb_pkg::priv_e        priv,
    input  itlb_pkg::satp_mode_t   satp_mode,
    input  logic                   hit_raw,
    input  itlb_pkg::ppn_t         sel_ppn,
    input  itlb_pkg::idx_t         sel_index,
    input  logic                   sel_fault,
    output itlb_pkg::ppn_t         ppn,
    output logic                   hit,
    output itlb_pkg::idx_t         hit_index,
    output logic                   fault
);

    logic bypass;

    // Translation off, or machine mode fetching physically
    assign bypass = (satp_mode == itlb_pkg::SATP_MODE_BARE) || (priv == itlb_pkg::PRIV_M);

    // ****************************************
    // Output register
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst || !re) begin
            ppn       <= '0;  // Idle cycles read as all zero
            hit       <= 1'b0;
            hit_index <= '0;
            fault     <= 1'b0;
        end else if (bypass) begin
            ppn       <= itlb_pkg::ppn_t'(vpn);  // Identity map
            hit       <= 1'b1;
            hit_index <= '0;
            fault     <= 1'b0;
        end else begin
            ppn       <= sel_ppn;
            hit       <= hit_raw;
            hit_index <= sel_index;
            fault     <= sel_fault;
        end
    end

    // A fault is only reported against a slot that actually hit
    fault_needs_hit_a: assert property (
        @(posedge clk) disable iff (rst) fault |-> hit
    ) else $error("fault raised without a TLB hit");

endmodule

// ==== src/itlb_top.sv ====
/*
 * Instruction TLB top level, 32 fully associative Sv39 entries.
 * Lookup on re returns PPN, hit, index and fault one clock later.
 */
`timescale 1ns/1ps

module itlb_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   re,
    input  itlb_pkg::vpn_t         vpn,
    input  itlb_pkg::priv_e        priv,
    input  itlb_pkg::satp_mode_t   satp_mode,
    input  logic                   we,
    input  itlb_pkg::idx_t         write_index,
    input  itlb_pkg::entry_t       write_entry,
    input  logic                   flush,
    output itlb_pkg::ppn_t         ppn,
    output logic                   hit,
    output itlb_pkg::idx_t         hit_index,
    output logic                   fault
);

    // ****************************************
    // Stage wiring
    // ****************************************
    itlb_pkg::entry_t   entries [itlb_pkg::NUM_ENTRIES];
    itlb_pkg::match_t   valid;
    itlb_pkg::match_t   match;      // Decode to execute
    logic               hit_raw;
    itlb_pkg::ppn_t     sel_ppn;    // Execute to result
    itlb_pkg::idx_t     sel_index;
    logic               sel_fault;

    itlb_entry_store store_i (
        .clk(clk), .rst(rst), .we(we), .write_index(write_index),
        .write_entry(write_entry), .flush(flush), .entries(entries), .valid(valid)
    );

    itlb_tag_match match_i (
        .re(re), .vpn(vpn), .entries(entries), .valid(valid),
        .match(match), .hit_raw(hit_raw)
    );

    itlb_perm_check perm_i (
        .match(match), .entries(entries), .priv(priv),
        .sel_ppn(sel_ppn), .sel_index(sel_index), .sel_fault(sel_fault)
    );

    itlb_result_reg result_i (
        .clk(clk), .rst(rst), .re(re), .vpn(vpn), .priv(priv), .satp_mode(satp_mode),
        .hit_raw(hit_raw), .sel_ppn(sel_ppn), .sel_index(sel_index), .sel_fault(sel_fault),
        .ppn(ppn), .hit(hit), .hit_index(hit_index), .fault(fault)
    );

endmodule

// ==== bench/itlb_checker.sv ====
/*
 * Result checker for the instruction TLB testbench.
 * Delays the expected values by the one cycle lookup latency and compares
 * them with the DUT outputs on the falling edge, one line per lookup test.
 */
`timescale 1ns/1ps

module itlb_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               chk_valid,
    input  logic               chk_lookup,
    input  int                 test_line,
    input  logic               exp_hit,
    input  itlb_pkg::ppn_t     exp_ppn,
    input  itlb_pkg::idx_t     exp_index,
    input  logic               exp_fault,
    input  itlb_pkg::ppn_t     ppn,
    input  logic               hit,
    input  itlb_pkg::idx_t     hit_index,
    input  logic               fault,
    output int                 checks_done,
    output int                 lookup_tests,
    output int                 failed_tests,
    output int                 error_count
);

    // Expected values lined up with the registered DUT result
    logic           stage_valid;
    logic           stage_lookup;
    int             stage_line;
    logic           stage_hit;
    itlb_pkg::ppn_t stage_ppn;
    itlb_pkg::idx_t stage_index;
    logic           stage_fault;

    always @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid  <= chk_valid;
            stage_lookup <= chk_lookup;
            stage_line   <= test_line;
            stage_hit    <= exp_hit;
            stage_ppn    <= exp_ppn;
            stage_index  <= exp_index;
            stage_fault  <= exp_fault;
        end
    end

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual, inout int mismatches);
        if (actual !== expected) begin
            $display("[FAIL] trace line %0d %s expected 0x%0h got 0x%0h",
                     stage_line, name, expected, actual);
            mismatches++;
        end
    endtask

    // ****************************************
    // Compare on the falling edge
    // ****************************************
    always @(negedge clk) begin : compare
        int mismatches;
        if (rst) begin
            checks_done  = 0;
            lookup_tests = 0;
            failed_tests = 0;
            error_count  = 0;
        end else if (stage_valid) begin
            mismatches = 0;
            check_field("hit", stage_hit, hit, mismatches);
            check_field("ppn", stage_ppn, ppn, mismatches);
            check_field("hit_index", stage_index, hit_index, mismatches);
            check_field("fault", stage_fault, fault, mismatches);
            checks_done = checks_done + 1;
            error_count = error_count + mismatches;
            if (stage_lookup) begin
                lookup_tests = lookup_tests + 1;
                if (mismatches == 0) begin
                    $display("Test %0d (trace line %0d) ok", lookup_tests, stage_line);
                end else begin
                    failed_tests = failed_tests + 1;
                    $display("Test %0d (trace line %0d) failed with %0d wrong outputs",
                             lookup_tests, stage_line, mismatches);
                end
            end
        end
    end

endmodule

// ==== bench/itlb_tb.sv ====
/*
 * Testbench top for the instruction TLB.
 * Replays bench/itlb_trace.txt one operation per clock into the DUT and
 * hands the expected lookup results to itlb_checker for comparison.
 */
`timescale 1ns/1ps

module itlb_tb;

    localparam int TRACE_DEPTH   = 64;
    localparam int RESET_CYCLES  = 16;
    localparam int TIMEOUT_SLACK = 20;

    // Operation codes in the first trace column
    localparam logic [3:0] OP_WRITE       = 4'h1;
    localparam logic [3:0] OP_FLUSH       = 4'h2;
    localparam logic [3:0] OP_LOOKUP      = 4'h3;
    localparam logic [3:0] OP_WRITE_FLUSH = 4'h4;

    logic                   clk;
    logic                   rst;
    logic                   re;
    itlb_pkg::vpn_t         vpn;
    itlb_pkg::priv_e        priv;
    itlb_pkg::satp_mode_t   satp_mode;
    logic                   we;
    itlb_pkg::idx_t         write_index;
    itlb_pkg::entry_t       write_entry;
    logic                   flush;
    itlb_pkg::ppn_t         ppn;
    logic                   hit;
    itlb_pkg::idx_t         hit_index;
    logic                   fault;

    // Handoff to the checker
    logic                   chk_valid;
    logic                   chk_lookup;
    int                     chk_line;
    logic                   exp_hit;
    itlb_pkg::ppn_t         exp_ppn;
    itlb_pkg::idx_t         exp_index;
    logic                   exp_fault;
    int                     checks_done;
    int                     lookup_tests;
    int                     failed_tests;
    int                     error_count;

    logic [107:0] trace_mem [TRACE_DEPTH];  // op_idx_vpn_ppn_u_v_priv_satp_hit_fault
    int trace_len;
    int trace_errors = 0;
    int cycle_count  = 0;
    int cycle_limit  = 1000;

    itlb_top dut_i (
        .clk(clk), .rst(rst), .re(re), .vpn(vpn), .priv(priv), .satp_mode(satp_mode),
        .we(we), .write_index(write_index), .write_entry(write_entry), .flush(flush),
        .ppn(ppn), .hit(hit), .hit_index(hit_index), .fault(fault)
    );

    itlb_checker checker_i (
        .clk(clk), .rst(rst), .chk_valid(chk_valid), .chk_lookup(chk_lookup),
        .test_line(chk_line), .exp_hit(exp_hit), .exp_ppn(exp_ppn),
        .exp_index(exp_index), .exp_fault(exp_fault),
        .ppn(ppn), .hit(hit), .hit_index(hit_index), .fault(fault),
        .checks_done(checks_done), .lookup_tests(lookup_tests),
        .failed_tests(failed_tests), .error_count(error_count)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ****************************************
    // Run limit
    // ****************************************
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the checker did not finish", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // One trace line onto the DUT inputs and the checker handoff
    task automatic apply_line(input logic [107:0] word, input int line_num);
        logic [3:0]       op;
        itlb_pkg::entry_t entry;
        op    = word[107:104];
        entry = '0;
        entry[itlb_pkg::PPN_LSB +: itlb_pkg::PPN_W] = word[67:24];
        entry[itlb_pkg::VPN_LSB +: itlb_pkg::VPN_W] = word[94:68];
        entry[itlb_pkg::ENTRY_U_BIT] = word[20];
        entry[itlb_pkg::ENTRY_V_BIT] = word[16];
        if (op > OP_WRITE_FLUSH) begin
            $display("Trace line %0d holds unknown operation %h", line_num, op);
            trace_errors++;
        end
        re          <= (op == OP_LOOKUP);
        we          <= (op == OP_WRITE) || (op == OP_WRITE_FLUSH);
        flush       <= (op == OP_FLUSH) || (op == OP_WRITE_FLUSH);
        write_index <= word[100:96];
        write_entry <= entry;
        vpn         <= word[94:68];
        priv        <= itlb_pkg::priv_e'(word[13:12]);
        satp_mode   <= word[11:8];
        chk_valid   <= 1'b1;
        chk_lookup  <= (op == OP_LOOKUP);
        chk_line    <= line_num;
        if (op == OP_LOOKUP) begin
            exp_hit   <= word[4];
            exp_ppn   <= word[67:24];
            exp_index <= word[100:96];
            exp_fault <= word[0];
        end else begin
            exp_hit   <= 1'b0;  // re low, all outputs zero
            exp_ppn   <= '0;
            exp_index <= '0;
            exp_fault <= 1'b0;
        end
    endtask

    // ****************************************
    // Stimulus
    // ****************************************
    initial begin
        rst         = 1'b1;
        re          = 1'b0;
        vpn         = '0;
        priv        = itlb_pkg::PRIV_U;
        satp_mode   = '0;
        we          = 1'b0;
        write_index = '0;
        write_entry = '0;
        flush       = 1'b0;
        chk_valid   = 1'b0;
        chk_lookup  = 1'b0;
        chk_line    = 0;
        exp_hit     = 1'b0;
        exp_ppn     = '0;
        exp_index   = '0;
        exp_fault   = 1'b0;

        $readmemh("bench/itlb_trace.txt", trace_mem);
        trace_len = 0;
        while (trace_len < TRACE_DEPTH && !$isunknown(trace_mem[trace_len])) begin
            trace_len++;
        end
        if (trace_len == 0) begin
            $display("Trace file holds no operations");
            trace_errors++;
        end
        cycle_limit = trace_len + RESET_CYCLES + TIMEOUT_SLACK;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < trace_len; i++) begin
            @(posedge clk);
            apply_line(trace_mem[i], i + 1);
        end
        @(posedge clk);
        re        <= 1'b0;  // Drain
        we        <= 1'b0;
        flush     <= 1'b0;
        chk_valid <= 1'b0;

        while (checks_done < trace_len) @(posedge clk);
        $display("Checks %0d, lookup tests %0d, failed tests %0d, mismatches %0d, trace errors %0d",
                 checks_done, lookup_tests, failed_tests, error_count, trace_errors);
        if (error_count == 0 && trace_errors == 0 && checks_done > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bench/itlb_trace.txt ====
// op_idx_vpn_ppn_u_v_priv_satp_hit_fault, one operation per clock, all hex
// op 0 idle, 1 write, 2 flush, 3 lookup, 4 write with flush
// Lookups carry the expected index and PPN in the idx and ppn columns
0_00_0000000_00000000000_0_0_0_0_0_0
// Refill four slots, slot 31 with V clear
1_00_0012345_00000ABCDE1_0_1_0_0_0_0
1_05_7654321_FEDCBA98765_1_1_0_0_0_0
1_1F_0000ABC_00012345678_0_0_0_0_0_0
1_0C_1111111_0A0B0C0D0E0_0_1_0_0_0_0
// Sv39 hits in S mode on non-user pages
3_00_0012345_00000ABCDE1_0_0_1_8_1_0
3_0C_1111111_0A0B0C0D0E0_0_0_1_8_1_0
// Misses and an idle cycle
3_00_0222222_00000000000_0_0_1_8_0_0
3_00_0000ABC_00000000000_0_0_1_8_0_0
0_00_0000000_00000000000_0_0_0_0_0_0
// Privilege rule
3_05_7654321_FEDCBA98765_0_0_1_8_1_1
3_00_0012345_00000ABCDE1_0_0_0_8_1_1
3_05_7654321_FEDCBA98765_0_0_0_8_1_0
// Bypass in Bare mode and in M mode
3_00_0222222_00000222222_0_0_0_0_1_0
3_00_7654321_00007654321_0_0_1_0_1_0
3_00_7FFFFFF_00007FFFFFF_0_0_3_8_1_0
3_00_0012345_00000012345_0_0_3_8_1_0
// Rewrite slot 0, then back to back lookups
1_00_0033333_00000F00D00_0_1_0_0_0_0
3_00_0033333_00000F00D00_0_0_1_8_1_0
3_00_0012345_00000000000_0_0_1_8_0_0
3_0C_1111111_0A0B0C0D0E0_0_0_1_8_1_0
3_05_7654321_FEDCBA98765_0_0_0_8_1_0
// Flush, then flush together with a write
2_00_0000000_00000000000_0_0_0_0_0_0
3_00_1111111_00000000000_0_0_1_8_0_0
3_00_0033333_00000000000_0_0_1_8_0_0
4_03_0444444_00000444444_0_1_0_0_0_0
3_00_0444444_00000000000_0_0_1_8_0_0
3_00_7654321_00000000000_0_0_0_8_0_0
// Refill after the flush
1_03_0555555_12345678ABC_1_1_0_0_0_0
3_03_0555555_12345678ABC_0_0_0_8_1_0
3_03_0555555_12345678ABC_0_0_1_8_1_1
0_00_0000000_00000000000_0_0_0_0_0_0

// ==== all.f ====
src/itlb_pkg.sv
src/itlb_entry_store.sv
src/itlb_tag_match.sv
src/itlb_perm_check.sv
src/itlb_result_reg.sv
src/itlb_top.sv
bench/itlb_checker.sv
bench/itlb_tb.sv

// ==== Bender.yml ====
package:
  name: itlb

sources:
  - src/itlb_pkg.sv
  - src/itlb_entry_store.sv
  - src/itlb_tag_match.sv
  - src/itlb_perm_check.sv
  - src/itlb_result_reg.sv
  - src/itlb_top.sv
  - target: simulation
    files:
      - bench/itlb_checker.sv
      - bench/itlb_tb.sv
